//--- rtl/maple_bus_pkg.sv
package maple_bus_pkg;

    typedef logic [7:0] maple_byte_t;
    typedef logic [4:0] byte_pos_t;  // saturates at 31

    // decoder to parser, one event word per cycle
    typedef struct packed {
        logic        byte_valid;
        maple_byte_t data;
        logic        start_detected;
        logic        end_detected;
    } maple_rx_t;

    // header bytes of a data reply frame
    localparam maple_byte_t frame_words_reply = 8'd3;
    localparam maple_byte_t addr_host         = 8'd0;  // console side
    localparam maple_byte_t cmd_data_reply    = 8'd8;

    // function codes in the first payload word
    localparam maple_byte_t func_controller   = 8'd1;
    localparam maple_byte_t func_keyboard     = 8'h40;

endpackage

//--- rtl/maple_report_pkg.sv
package maple_report_pkg;

    typedef struct packed {
        logic valid_packet;
        logic trigger_osd;
        logic trigger_default_resolution;
        logic ltrigger;  // fully pressed only
        logic rtrigger;
        logic x;
        logic y;
        logic a;
        logic b;
        logic start;
        logic up;
        logic down;
        logic left;
        logic right;
    } controller_data_t;

    typedef struct packed {
        logic                       valid_packet;
        maple_bus_pkg::maple_byte_t shiftcode;
        maple_bus_pkg::maple_byte_t leds;
        maple_bus_pkg::maple_byte_t key1;
        maple_bus_pkg::maple_byte_t key2;
        maple_bus_pkg::maple_byte_t key3;
        maple_bus_pkg::maple_byte_t key4;
        maple_bus_pkg::maple_byte_t key5;
        maple_bus_pkg::maple_byte_t key6;
    } keyboard_data_t;

endpackage

//--- rtl/maple_in.sv
`timescale 1ns/1ps

module maple_in #(
    parameter int sync_stages = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     pin1,
    input  logic                     pin5,
    input  logic                     arm,
    output logic                     bus_active,
    output maple_bus_pkg::maple_rx_t rx
);
    import maple_bus_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_armed,
        st_start_count,
        st_data,
        st_end_count
    } state_t;

    state_t                 state;
    logic [sync_stages-1:0] pin1_sync;
    logic [sync_stages-1:0] pin5_sync;
    logic                   pin1_s;
    logic                   pin5_s;
    logic                   pin1_q;
    logic                   pin5_q;
    logic                   pin1_fall;
    logic                   pin1_rise;
    logic                   pin5_fall;
    logic                   pin5_rise;
    logic [2:0]             edge_cnt;
    logic [2:0]             bit_cnt;
    logic [6:0]             shift;
    logic                   sample_en;
    logic                   sample_bit;
    logic                   end_hit;

    // lines idle high, so start the chain at one to avoid a false fall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pin1_sync <= '1;
            pin5_sync <= '1;
            pin1_q    <= 1'b1;
            pin5_q    <= 1'b1;
        end else begin
            pin1_sync <= {pin1_sync[sync_stages-2:0], pin1};
            pin5_sync <= {pin5_sync[sync_stages-2:0], pin5};
            pin1_q    <= pin1_s;
            pin5_q    <= pin5_s;
        end
    end

    assign pin1_s = pin1_sync[sync_stages-1];
    assign pin5_s = pin5_sync[sync_stages-1];

    assign pin1_fall = pin1_q & ~pin1_s;
    assign pin1_rise = ~pin1_q & pin1_s;
    assign pin5_fall = pin5_q & ~pin5_s;
    assign pin5_rise = ~pin5_q & pin5_s;

    // each line's fall clocks in the other line
    assign sample_en  = pin1_fall | pin5_fall;
    assign sample_bit = pin1_fall ? pin5_s : pin1_s;

    // second pin1 fall with pin5 held low and no pin5 fall in between
    assign end_hit = pin1_fall & ~pin5_s & (edge_cnt == 3'd1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= st_idle;
            edge_cnt   <= '0;
            bit_cnt    <= '0;
            shift      <= '0;
            bus_active <= 1'b0;
            rx         <= '0;
        end else begin
            rx.byte_valid     <= 1'b0;
            rx.start_detected <= 1'b0;
            rx.end_detected   <= 1'b0;

            case (state)
                st_idle: begin
                    if (arm) begin
                        state <= st_armed;
                    end
                end
                st_armed: begin
                    if (pin1_fall) begin
                        edge_cnt <= '0;
                        state    <= st_start_count;
                    end
                end
                st_start_count: begin
                    if (pin1_rise) begin
                        if (edge_cnt == 3'd4) begin
                            rx.start_detected <= 1'b1;
                            bus_active        <= 1'b1;
                            bit_cnt           <= '0;
                            edge_cnt          <= '0;
                            state             <= st_data;
                        end else begin
                            state <= st_armed;  // wrong count, look again
                        end
                    end else if (pin5_fall && edge_cnt != 3'd7) begin
                        edge_cnt <= edge_cnt + 3'd1;
                    end
                end
                st_data: begin
                    if (end_hit) begin
                        state <= st_end_count;
                    end else if (sample_en) begin
                        shift   <= {shift[5:0], sample_bit};
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            rx.byte_valid <= 1'b1;
                            rx.data       <= {shift, sample_bit};
                        end
                        // run of pin1 falls with pin5 low
                        edge_cnt <= (pin1_fall && !pin5_s) ? edge_cnt + 3'd1 : 3'd0;
                    end
                end
                st_end_count: begin
                    if (pin5_rise) begin
                        rx.end_detected <= 1'b1;
                        bus_active      <= 1'b0;
                        state           <= st_idle;  // wait for next arm
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- rtl/maple.sv
`timescale 1ns/1ps

module maple (
    input  logic                               clk,
    input  logic                               reset,
    input  maple_bus_pkg::maple_rx_t           rx,
    output logic                               arm,
    output maple_report_pkg::controller_data_t controller_data,
    output maple_report_pkg::keyboard_data_t   keyboard_data
);
    import maple_bus_pkg::*;
    import maple_report_pkg::*;

    localparam maple_byte_t trigger_full   = 8'hFF;
    localparam maple_byte_t osd_buttons_hi = 8'hF3;  // X
    localparam maple_byte_t osd_buttons_lo = 8'hF3;  // A + start
    localparam maple_byte_t res_buttons_hi = 8'hFD;  // Y
    localparam maple_byte_t res_buttons_lo = 8'hF5;  // B + start

    byte_pos_t        pos;
    logic [3:0]       ctrl_check;
    logic [3:0]       kbd_check;
    logic [3:0]       osd_hits;
    logic [3:0]       res_hits;
    controller_data_t cdata_in;
    keyboard_data_t   kdata_in;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            arm             <= 1'b1;  // arm the decoder right out of reset
            pos             <= '0;
            ctrl_check      <= '0;
            kbd_check       <= '0;
            osd_hits        <= '0;
            res_hits        <= '0;
            cdata_in        <= '0;
            kdata_in        <= '0;
            controller_data <= '0;
            keyboard_data   <= '0;
        end else begin
            arm <= rx.end_detected;

            // publish only fully matched headers
            if (rx.end_detected) begin
                if (&ctrl_check) begin
                    controller_data                            <= cdata_in;
                    controller_data.valid_packet               <= 1'b1;
                    controller_data.trigger_osd                <= &osd_hits;
                    controller_data.trigger_default_resolution <= &res_hits;
                end
                if (&kbd_check) begin
                    keyboard_data              <= kdata_in;
                    keyboard_data.valid_packet <= 1'b1;
                end
            end

            if (rx.start_detected || rx.end_detected) begin
                pos        <= '0;
                ctrl_check <= '0;
                kbd_check  <= '0;
                osd_hits   <= '0;
                res_hits   <= '0;
                cdata_in   <= '0;
                kdata_in   <= '0;
            end else if (rx.byte_valid) begin
                case (pos)
                    5'd0: begin
                        if (rx.data == frame_words_reply) begin
                            ctrl_check[0] <= 1'b1;
                            kbd_check[0]  <= 1'b1;
                        end
                    end
                    5'd2: begin
                        if (rx.data == addr_host) begin
                            ctrl_check[1] <= 1'b1;
                            kbd_check[1]  <= 1'b1;
                        end
                    end
                    5'd3: begin
                        if (rx.data == cmd_data_reply) begin
                            ctrl_check[2] <= 1'b1;
                            kbd_check[2]  <= 1'b1;
                        end
                    end
                    5'd4: begin
                        if (rx.data == func_controller) begin
                            ctrl_check[3] <= 1'b1;
                        end else if (rx.data == func_keyboard) begin
                            kbd_check[3] <= 1'b1;
                        end
                    end
                    5'd8: begin
                        cdata_in.ltrigger <= (rx.data == trigger_full);
                        kdata_in.key2     <= rx.data;
                        if (rx.data == trigger_full) begin
                            osd_hits[0] <= 1'b1;
                            res_hits[0] <= 1'b1;
                        end
                    end
                    5'd9: begin
                        cdata_in.rtrigger <= (rx.data == trigger_full);
                        kdata_in.key1     <= rx.data;
                        if (rx.data == trigger_full) begin
                            osd_hits[1] <= 1'b1;
                            res_hits[1] <= 1'b1;
                        end
                    end
                    5'd10: begin
                        // buttons are active low
                        cdata_in.y    <= ~rx.data[1];
                        cdata_in.x    <= ~rx.data[2];
                        kdata_in.leds <= rx.data;
                        osd_hits[2]   <= (rx.data == osd_buttons_hi);
                        res_hits[2]   <= (rx.data == res_buttons_hi);
                    end
                    5'd11: begin
                        cdata_in.b         <= ~rx.data[1];
                        cdata_in.a         <= ~rx.data[2];
                        cdata_in.start     <= ~rx.data[3];
                        cdata_in.up        <= ~rx.data[4];
                        cdata_in.down      <= ~rx.data[5];
                        cdata_in.left      <= ~rx.data[6];
                        cdata_in.right     <= ~rx.data[7];
                        kdata_in.shiftcode <= rx.data;
                        osd_hits[3]        <= (rx.data == osd_buttons_lo);
                        res_hits[3]        <= (rx.data == res_buttons_lo);
                    end
                    5'd12: kdata_in.key6 <= rx.data;
                    5'd13: kdata_in.key5 <= rx.data;
                    5'd14: kdata_in.key4 <= rx.data;
                    5'd15: kdata_in.key3 <= rx.data;
                    default: begin
                        // sender address and trailing words not used
                    end
                endcase
                if (pos != '1) begin
                    pos <= pos + 5'd1;
                end
            end
        end
    end

endmodule

//--- rtl/maple_snoop_top.sv
`timescale 1ns/1ps

module maple_snoop_top #(
    parameter int sync_stages = 2
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               pin1,
    input  logic                               pin5,
    output logic                               bus_active,
    output maple_report_pkg::controller_data_t controller_data,
    output maple_report_pkg::keyboard_data_t   keyboard_data
);
    import maple_bus_pkg::*;

    maple_rx_t rx;
    logic      arm;  // parser re-arms the decoder

    maple_in #(
        .sync_stages(sync_stages)
    ) maple_in_i (
        .clk        (clk),
        .reset      (reset),
        .pin1       (pin1),
        .pin5       (pin5),
        .arm        (arm),
        .bus_active (bus_active),
        .rx         (rx)
    );

    maple maple_i (
        .clk             (clk),
        .reset           (reset),
        .rx              (rx),
        .arm             (arm),
        .controller_data (controller_data),
        .keyboard_data   (keyboard_data)
    );

endmodule

//--- test/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset
);
    always #20 clk = ~clk;  // 40 ns period

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

//--- test/maple_tb.sv
`timescale 1ns/1ps

module maple_tb;
    import maple_report_pkg::*;

    localparam int record_words = 19;  // count, 16 bytes, two reports
    localparam int max_records  = 26;
    localparam int mem_words    = 512;
    localparam int reset_limit  = 20;
    localparam int rise_limit   = 200;
    localparam int fall_limit   = 4000;

    logic             clk;
    logic             reset;
    logic             pin1;
    logic             pin5;
    logic             bus_active;
    controller_data_t controller_data;
    keyboard_data_t   keyboard_data;
    logic [67:0]      pattern_mem [0:mem_words-1];
    int               check_count;
    int               mismatch_count;
    int               fail_count;

    clock_gen clock_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    maple_snoop_top #(
        .sync_stages(2)
    ) maple_snoop_top_i (
        .clk             (clk),
        .reset           (reset),
        .pin1            (pin1),
        .pin5            (pin5),
        .bus_active      (bus_active),
        .controller_data (controller_data),
        .keyboard_data   (keyboard_data)
    );

    task automatic check_value(input string what, input logic [67:0] got,
                               input logic [67:0] expected);
        check_count++;
        if (got !== expected) begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // change 2 ns after an edge, hold for four clocks, return just after an edge
    task automatic set_lines(input logic p1, input logic p5);
        @(posedge clk);
        #2;
        pin1 = p1;
        pin5 = p5;
        repeat (3) @(posedge clk);
        #1;
    endtask

    // pin5 holds the bit, pin1 falls
    task automatic send_bit_on_pin5(input logic value);
        if (!pin1)
            set_lines(1'b1, pin5);
        if (pin5 != value)
            set_lines(pin1, value);  // only ever a rise here
        set_lines(1'b0, pin5);
    endtask

    // pin1 holds the bit, pin5 falls
    task automatic send_bit_on_pin1(input logic value);
        if (pin1 != value)
            set_lines(value, pin5);
        if (!pin5)
            set_lines(pin1, 1'b1);
        set_lines(pin1, 1'b0);
    endtask

    task automatic send_packet(input int base, input int count);
        logic [7:0] data;
        int         i;
        int         k;
        set_lines(1'b0, 1'b1);
        for (k = 0; k < 4; k++) begin
            set_lines(1'b0, 1'b0);
            if (k < 3)
                set_lines(1'b0, 1'b1);
        end
        set_lines(1'b1, 1'b0);  // pin5 stays low into the first bit
        for (i = 0; i < count; i++) begin
            data = pattern_mem[9'(base + 1 + i)][7:0];
            repeat (4) begin
                send_bit_on_pin5(data[7]);
                send_bit_on_pin1(data[6]);
                data = data << 2;
            end
        end
        // end pattern, pin5 low through two pin1 falls
        if (!pin1)
            set_lines(1'b1, 1'b0);
        set_lines(1'b0, 1'b0);
        set_lines(1'b1, 1'b0);
        set_lines(1'b0, 1'b0);
        set_lines(1'b0, 1'b1);
        set_lines(1'b1, 1'b1);
    endtask

    task automatic watch_packet(input int rec, input logic [67:0] exp_ctrl,
                                input logic [67:0] exp_kbd);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!bus_active && n < rise_limit);
        if (!bus_active) begin
            fail_count++;
            $display("timeout: bus_active never rose for record %0d", rec);
        end else begin
            n = 0;
            while (bus_active && n < fall_limit) begin
                @(posedge clk);
                #1;
                n++;
            end
            if (bus_active) begin
                fail_count++;
                $display("timeout: bus_active never fell for record %0d", rec);
            end else begin
                @(posedge clk);  // reports follow one clock later
                #1;
                check_value($sformatf("controller_data, record %0d", rec),
                            68'(controller_data), exp_ctrl);
                check_value($sformatf("keyboard_data, record %0d", rec),
                            68'(keyboard_data), exp_kbd);
            end
        end
    endtask

    // pin5 noise, then a start with only two pin5 falls
    task automatic line_burst();
        logic [9:0] p1_seq;
        logic [9:0] p5_seq;
        p1_seq = 10'b1111000001;
        p5_seq = 10'b0101101011;
        repeat (10) begin
            set_lines(p1_seq[9], p5_seq[9]);
            check_value("bus_active during burst", 68'(bus_active), 68'd0);
            p1_seq = p1_seq << 1;
            p5_seq = p5_seq << 1;
        end
    endtask

    initial begin
        int rec_count;
        int base;
        int gap;
        int n;
        pin1           = 1'b1;
        pin5           = 1'b1;
        check_count    = 0;
        mismatch_count = 0;
        fail_count     = 0;
        void'($urandom(32'h6eb03377));
        $readmemh("test/maple_patterns.txt", pattern_mem);
        rec_count = int'(pattern_mem[0][7:0]);

        n = 0;
        while (reset !== 1'b0 && n < reset_limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (reset !== 1'b0) begin
            fail_count++;
            $display("reset was never released");
        end else begin
            repeat (2) @(posedge clk);
            #1;
            check_value("controller_data after reset", 68'(controller_data), 68'd0);
            check_value("keyboard_data after reset", 68'(keyboard_data), 68'd0);
            line_burst();
            repeat (8) @(posedge clk);
            #1;
            check_value("controller_data after burst", 68'(controller_data), 68'd0);
            check_value("keyboard_data after burst", 68'(keyboard_data), 68'd0);

            if (rec_count == 0 || rec_count > max_records) begin
                fail_count++;
                $display("pattern file gives no usable record count");
            end else begin
                for (int r = 0; r < rec_count; r++) begin
                    base = 1 + r * record_words;
                    gap  = 4 + $urandom % 17;
                    repeat (gap) @(posedge clk);
                    fork
                        send_packet(base, int'(pattern_mem[9'(base)][7:0]));
                        watch_packet(r, pattern_mem[9'(base + 17)],
                                     pattern_mem[9'(base + 18)]);
                    join
                end
            end
        end

        $display("checks %0d, mismatches %0d, other failures %0d",
                 check_count, mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0 && check_count > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- test/maple_patterns.txt
// first word: number of records; then one record per line, all hex:
// byte count, 16 packet bytes (unused ones 00), expected controller_data, expected keyboard_data
0D
// controller, left trigger, X, B and right
0C 03 20 00 08 01 00 00 00 FF 80 FB 7D 00 00 00 00 2521 0
// keyboard, controller report held
10 03 20 00 08 40 00 00 00 05 04 02 22 09 08 07 06 2521 12202040506070809
// wrong command byte, both held
0C 03 20 00 07 01 00 00 00 FF FF F3 F3 00 00 00 00 2521 12202040506070809
// wrong recipient, both held
10 03 20 01 08 40 00 00 00 11 12 13 14 15 16 17 18 2521 12202040506070809
// both triggers, X and A+start: osd hotkey
0C 03 20 00 08 01 00 00 00 FF FF F3 F3 00 00 00 00 3750 12202040506070809
// both triggers, Y and B+start: resolution hotkey
0C 03 20 00 08 01 00 00 00 FF FF FD F5 00 00 00 00 2EB0 12202040506070809
// near misses, no hotkey
0C 03 20 00 08 01 00 00 00 FF FE F3 F3 00 00 00 00 2550 12202040506070809
0C 03 20 00 08 01 00 00 00 FF FF F3 F5 00 00 00 00 2730 12202040506070809
// mixed traffic with short gaps
10 03 20 00 08 40 00 00 00 1D 1C 01 02 21 20 1F 1E 2730 102011C1D1E1F2021
0C 03 20 00 08 01 00 00 00 00 00 FF FF 00 00 00 00 2000 102011C1D1E1F2021
0C 03 20 00 08 01 00 00 00 00 FF F9 0F 00 00 00 00 238F 102011C1D1E1F2021
// bad frame word count
10 04 20 00 08 40 00 00 00 AA AB AC AD AE AF B0 B1 238F 102011C1D1E1F2021
10 03 20 00 08 40 00 00 00 00 00 00 00 00 00 00 00 238F 10000000000000000

//--- sim.f
rtl/maple_bus_pkg.sv
rtl/maple_report_pkg.sv
rtl/maple_in.sv
rtl/maple.sv
rtl/maple_snoop_top.sv
test/clock_gen.sv
test/maple_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the Maple snooper testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 -f sim.f --top-module maple_tb -o maple_tb_sim \
    > build.log 2>&1 \
    && ./obj_dir/maple_tb_sim > sim.log 2>&1 \
    && cat sim.log \
    && grep -qx "Test OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
